//--- src/coreSettings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

////////////////////
// fetch
////////////////////

// address fetched first after reset.
`define CORE_RESET_PC 32'h0000_0000

////////////////////
// register file
////////////////////

// architectural integer registers including x0.
`define CORE_NUM_REGS 32

`endif

//--- src/corePkg.sv
package corePkg;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt,
        aluSltu, aluXor, aluSrl, aluSra,
        aluOr, aluAnd,
        aluPassB
    } aluOp;

    typedef enum logic [2:0] {
        brNone, brBeq, brBne, brBlt,
        brBge, brBltu, brBgeu, brJump
    } branchOp;

    typedef enum logic [1:0] {
        memNone, memLoad, memStore
    } memOp;

    ////////////////////
    // instruction formats
    ////////////////////

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rFormat;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iFormat;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sFormat;

    // the sFormat layout with the immediate scrambled for branch offsets.
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bFormat;

    typedef union packed {
        rFormat rType;
        iFormat iType;
        sFormat sType;
        bFormat bType;
    } instrWord;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] imm;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        aluOp        alu;
        branchOp     branch;
        memOp        mem;
        logic [1:0]  memSize;
        logic        useImm;
        logic        usePc;
        logic        writesRd;
        logic        linkResult;
        logic        jalrTarget;
    } microOp;

endpackage

//--- src/programCounter.sv
`timescale 1ns/10ps

`include "coreSettings.svh"

module programCounter (
    input  logic        clk,
    input  logic        rst,
    input  logic        advance,
    input  logic        redirect,
    input  logic [31:0] target,
    output logic [31:0] pc
);

    logic [31:0] pcNext;

    // a redirect from execute beats the sequential step.
    always_comb begin
        if (redirect) begin
            pcNext = target;
        end else if (advance) begin
            pcNext = pc + 32'd4;
        end else begin
            pcNext = pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `CORE_RESET_PC;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

//--- src/instrDecoder.sv
`timescale 1ns/10ps

module instrDecoder (
    input  corePkg::instrWord instr,
    input  logic [31:0]       pc,
    output corePkg::microOp   uop
);
    import corePkg::*;

    localparam logic [6:0] opcLui    = 7'b0110111;
    localparam logic [6:0] opcAuipc  = 7'b0010111;
    localparam logic [6:0] opcJal    = 7'b1101111;
    localparam logic [6:0] opcJalr   = 7'b1100111;
    localparam logic [6:0] opcBranch = 7'b1100011;
    localparam logic [6:0] opcLoad   = 7'b0000011;
    localparam logic [6:0] opcStore  = 7'b0100011;
    localparam logic [6:0] opcOpImm  = 7'b0010011;
    localparam logic [6:0] opcOp     = 7'b0110011;

    logic [31:0] iImm;
    logic [31:0] sImm;
    logic [31:0] bImm;
    logic [31:0] uImm;
    logic [31:0] jImm;
    logic        shiftRight;

    // alt selects SUB over ADD and SRA over SRL.
    function automatic aluOp aluFromFunct3(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  return alt ? aluSub : aluAdd;
            3'b001:  return aluSll;
            3'b010:  return aluSlt;
            3'b011:  return aluSltu;
            3'b100:  return aluXor;
            3'b101:  return alt ? aluSra : aluSrl;
            3'b110:  return aluOr;
            default: return aluAnd;
        endcase
    endfunction

    function automatic branchOp branchFromFunct3(input logic [2:0] funct3);
        case (funct3)
            3'b000:  return brBeq;
            3'b001:  return brBne;
            3'b100:  return brBlt;
            3'b101:  return brBge;
            3'b110:  return brBltu;
            3'b111:  return brBgeu;
            default: return brNone;
        endcase
    endfunction

    assign iImm = {{20{instr.iType.imm[11]}}, instr.iType.imm};
    assign sImm = {{20{instr.sType.immHi[6]}}, instr.sType.immHi, instr.sType.immLo};
    assign bImm = {{19{instr.bType.imm12}}, instr.bType.imm12, instr.bType.imm11,
                   instr.bType.imm10to5, instr.bType.imm4to1, 1'b0};
    assign uImm = {instr.rType.funct7, instr.rType.rs2, instr.rType.rs1,
                   instr.rType.funct3, 12'b0};
    // J offset bits sit in the I view's imm, rs1 and funct3 fields.
    assign jImm = {{12{instr.iType.imm[11]}}, instr.iType.rs1, instr.iType.funct3,
                   instr.iType.imm[0], instr.iType.imm[10:1], 1'b0};
    assign shiftRight = (instr.iType.funct3 == 3'b101);

    always_comb begin
        uop = '0;
        uop.pc = pc;
        case (instr.rType.opcode)
            opcLui: begin
                uop.valid = 1'b1;
                uop.rd = instr.rType.rd;
                uop.imm = uImm;
                uop.alu = aluPassB;
                uop.useImm = 1'b1;
                uop.writesRd = 1'b1;
            end
            opcAuipc: begin
                uop.valid = 1'b1;
                uop.rd = instr.rType.rd;
                uop.imm = uImm;
                uop.usePc = 1'b1;
                uop.useImm = 1'b1;
                uop.writesRd = 1'b1;
            end
            opcJal, opcJalr: begin
                uop.valid = 1'b1;
                uop.rd = instr.rType.rd;
                uop.branch = brJump;
                uop.usePc = 1'b1;
                uop.writesRd = 1'b1;
                uop.linkResult = 1'b1;
                uop.jalrTarget = (instr.rType.opcode == opcJalr);
                uop.rs1 = uop.jalrTarget ? instr.iType.rs1 : 5'd0;
                uop.imm = uop.jalrTarget ? iImm : jImm;
            end
            opcBranch: begin
                uop.branch = branchFromFunct3(instr.bType.funct3);
                uop.valid = (uop.branch != brNone);
                uop.rs1 = instr.bType.rs1;
                uop.rs2 = instr.bType.rs2;
                uop.imm = bImm;
            end
            opcLoad: begin
                // word loads only.
                if (instr.iType.funct3 == 3'b010) begin
                    uop.valid = 1'b1;
                    uop.rd = instr.iType.rd;
                    uop.rs1 = instr.iType.rs1;
                    uop.imm = iImm;
                    uop.useImm = 1'b1;
                    uop.writesRd = 1'b1;
                    uop.mem = memLoad;
                    uop.memSize = 2'b10;
                end
            end
            opcStore: begin
                if (instr.sType.funct3[2] == 1'b0 && instr.sType.funct3[1:0] != 2'b11) begin
                    uop.valid = 1'b1;
                    uop.rs1 = instr.sType.rs1;
                    uop.rs2 = instr.sType.rs2;
                    uop.imm = sImm;
                    uop.mem = memStore;
                    uop.memSize = instr.sType.funct3[1:0];
                end
            end
            opcOpImm: begin
                uop.valid = 1'b1;
                uop.rd = instr.iType.rd;
                uop.rs1 = instr.iType.rs1;
                uop.imm = iImm;
                uop.useImm = 1'b1;
                uop.writesRd = 1'b1;
                uop.alu = aluFromFunct3(instr.iType.funct3, shiftRight && instr.iType.imm[10]);
            end
            opcOp: begin
                uop.valid = 1'b1;
                uop.rd = instr.rType.rd;
                uop.rs1 = instr.rType.rs1;
                uop.rs2 = instr.rType.rs2;
                uop.writesRd = 1'b1;
                uop.alu = aluFromFunct3(instr.rType.funct3, instr.rType.funct7[5]);
            end
            default: begin
            end
        endcase
    end

endmodule

//--- src/regFile.sv
`timescale 1ns/10ps

`include "coreSettings.svh"

module regFile (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  readAddrA,
    input  logic [4:0]  readAddrB,
    output logic [31:0] readDataA,
    output logic [31:0] readDataB,
    input  logic        writeEnable,
    input  logic [4:0]  writeAddr,
    input  logic [31:0] writeData
);

    logic [31:0] regs [`CORE_NUM_REGS];
    logic        writeLive;

    // x0 is never written, so it reads zero from reset on.
    assign writeLive = writeEnable && (writeAddr != 5'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeLive) begin
            regs[writeAddr] <= writeData;
        end
    end

    // decode sees the value retiring this cycle through the bypass.
    assign readDataA = (writeLive && writeAddr == readAddrA) ? writeData : regs[readAddrA];
    assign readDataB = (writeLive && writeAddr == readAddrB) ? writeData : regs[readAddrB];

endmodule

//--- src/intAlu.sv
`timescale 1ns/10ps

module intAlu (
    input  corePkg::microOp uop,
    input  logic [31:0]     opA,
    input  logic [31:0]     opB,
    output logic [31:0]     result,
    output logic            redirect,
    output logic [31:0]     target
);
    import corePkg::*;

    logic [31:0] srcA;
    logic [31:0] srcB;
    logic [4:0]  shamt;
    logic [31:0] aluOut;
    logic        taken;
    logic [31:0] jalrSum;

    assign srcA = uop.usePc ? uop.pc : opA;
    assign srcB = uop.useImm ? uop.imm : opB;
    assign shamt = srcB[4:0];

    ////////////////////
    // arithmetic
    ////////////////////

    always_comb begin
        case (uop.alu)
            aluAdd:   aluOut = srcA + srcB;
            aluSub:   aluOut = srcA - srcB;
            aluSll:   aluOut = srcA << shamt;
            aluSlt:   aluOut = ($signed(srcA) < $signed(srcB)) ? 32'd1 : 32'd0;
            aluSltu:  aluOut = (srcA < srcB) ? 32'd1 : 32'd0;
            aluXor:   aluOut = srcA ^ srcB;
            aluSrl:   aluOut = srcA >> shamt;
            aluSra:   aluOut = $signed(srcA) >>> shamt;
            aluOr:    aluOut = srcA | srcB;
            aluAnd:   aluOut = srcA & srcB;
            aluPassB: aluOut = srcB;
            default:  aluOut = srcA + srcB;
        endcase
    end

    // jumps write the return address.
    assign result = uop.linkResult ? (uop.pc + 32'd4) : aluOut;

    ////////////////////
    // branches
    ////////////////////

    // conditions compare the register operands, never the immediate.
    always_comb begin
        case (uop.branch)
            brBeq:   taken = (opA == opB);
            brBne:   taken = (opA != opB);
            brBlt:   taken = ($signed(opA) < $signed(opB));
            brBge:   taken = ($signed(opA) >= $signed(opB));
            brBltu:  taken = (opA < opB);
            brBgeu:  taken = (opA >= opB);
            brJump:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign jalrSum = opA + uop.imm;
    assign target = uop.jalrTarget ? {jalrSum[31:1], 1'b0} : (uop.pc + uop.imm);
    assign redirect = uop.valid && taken;

endmodule

//--- src/lsu.sv
`timescale 1ns/10ps

module lsu (
    input  logic            clk,
    input  logic            rst,
    input  corePkg::microOp uop,
    input  logic [31:0]     opA,
    input  logic [31:0]     opB,
    output logic [31:0]     memAddr,
    output logic [31:0]     memWriteData,
    output logic            memWriteEnable,
    output logic            memReadEnable,
    output logic [3:0]      memWriteMask,
    input  logic [31:0]     memReadData,
    output logic [31:0]     loadData
);
    import corePkg::*;

    logic readPending;

    assign memAddr = opA + uop.imm;
    assign memReadEnable = uop.valid && (uop.mem == memLoad);
    assign memWriteEnable = uop.valid && (uop.mem == memStore);

    // narrow stores repeat the data on every lane, the mask picks one.
    always_comb begin
        case (uop.memSize)
            2'b00: begin
                memWriteData = {4{opB[7:0]}};
                memWriteMask = 4'b0001 << memAddr[1:0];
            end
            2'b01: begin
                memWriteData = {2{opB[15:0]}};
                memWriteMask = memAddr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                memWriteData = opB;
                memWriteMask = 4'b1111;
            end
        endcase
    end

    // read data returns while the load sits in writeback.
    always_ff @(posedge clk) begin
        if (rst) begin
            readPending <= 1'b0;
        end else begin
            readPending <= memReadEnable;
        end
    end

    assign loadData = readPending ? memReadData : 32'd0;

endmodule

//--- src/core.sv
`timescale 1ns/10ps

module core (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] instr,
    output logic [31:0] pc,
    input  logic [31:0] memReadData,
    output logic [31:0] memAddr,
    output logic [31:0] memWriteData,
    output logic        memWriteEnable,
    output logic        memReadEnable,
    output logic [3:0]  memWriteMask
);
    import corePkg::*;

    logic [31:0] decodePc;
    logic        decodeValid;
    logic [31:0] heldInstr;
    logic        heldValid;
    logic [31:0] decodeInstr;
    microOp      decUop;
    logic [31:0] rfDataA;
    logic [31:0] rfDataB;
    microOp      exUop;
    microOp      exLive;
    logic        exValid;
    logic [31:0] exRegA;
    logic [31:0] exRegB;
    logic [31:0] exOpA;
    logic [31:0] exOpB;
    logic [31:0] aluResult;
    logic [31:0] branchTarget;
    logic        redirect;
    logic        stall;
    logic        wbValid;
    logic        wbWritesRd;
    logic        wbIsLoad;
    logic [4:0]  wbRd;
    logic [31:0] wbResult;
    logic [31:0] wbData;
    logic        wbWriteEnable;
    logic [31:0] loadData;

    ////////////////////
    // fetch and decode
    ////////////////////

    programCounter u_programCounter (
        .clk(clk), .rst(rst), .advance(!stall), .redirect(redirect),
        .target(branchTarget), .pc(pc)
    );

    // memory has moved on during a stall, so decode replays the saved word.
    assign decodeInstr = heldValid ? heldInstr : instr;

    instrDecoder u_instrDecoder (.instr(decodeInstr), .pc(decodePc), .uop(decUop));

    regFile u_regFile (
        .clk(clk), .rst(rst),
        .readAddrA(decUop.rs1), .readAddrB(decUop.rs2),
        .readDataA(rfDataA), .readDataB(rfDataB),
        .writeEnable(wbWriteEnable), .writeAddr(wbRd), .writeData(wbData)
    );

    // load in execute feeding the instruction in decode.
    assign stall = decodeValid && decUop.valid && exValid && (exUop.mem == memLoad)
                   && (exUop.rd != 5'd0) && (exUop.rd == decUop.rs1 || exUop.rd == decUop.rs2)
                   && !redirect;

    ////////////////////
    // execute
    ////////////////////

    always_comb begin
        exLive = exUop;
        exLive.valid = exValid;
    end

    assign exOpA = (wbWriteEnable && wbRd != 5'd0 && wbRd == exUop.rs1) ? wbData : exRegA;
    assign exOpB = (wbWriteEnable && wbRd != 5'd0 && wbRd == exUop.rs2) ? wbData : exRegB;

    intAlu u_intAlu (
        .uop(exLive), .opA(exOpA), .opB(exOpB),
        .result(aluResult), .redirect(redirect), .target(branchTarget)
    );

    lsu u_lsu (
        .clk(clk), .rst(rst), .uop(exLive), .opA(exOpA), .opB(exOpB),
        .memAddr(memAddr), .memWriteData(memWriteData),
        .memWriteEnable(memWriteEnable), .memReadEnable(memReadEnable),
        .memWriteMask(memWriteMask), .memReadData(memReadData), .loadData(loadData)
    );

    ////////////////////
    // writeback
    ////////////////////

    assign wbWriteEnable = wbValid && wbWritesRd;
    assign wbData = wbIsLoad ? loadData : wbResult;

    // a taken branch squashes what sits in decode and what decode would pass on.
    always_ff @(posedge clk) begin
        if (rst) begin
            decodeValid <= 1'b0;
            heldValid <= 1'b0;
            exValid <= 1'b0;
            wbValid <= 1'b0;
        end else begin
            decodeValid <= !redirect;
            heldValid <= stall;
            exValid <= decodeValid && decUop.valid && !stall && !redirect;
            wbValid <= exValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            decodePc <= pc;
        end
        if (stall) begin
            heldInstr <= decodeInstr;
        end
        exUop <= decUop;
        exRegA <= rfDataA;
        exRegB <= rfDataB;
        wbRd <= exUop.rd;
        wbWritesRd <= exUop.writesRd;
        wbIsLoad <= (exUop.mem == memLoad);
        wbResult <= aluResult;
    end

endmodule

//--- tb/coreTb.sv
`timescale 1ns/10ps

`include "coreSettings.svh"

module coreTb;

    logic        clk;
    logic        rst;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] memReadData;
    logic [31:0] memAddr;
    logic [31:0] memWriteData;
    logic        memWriteEnable;
    logic        memReadEnable;
    logic [3:0]  memWriteMask;

    logic [31:0] vectors [0:511];
    logic [31:0] instrMem [0:255];
    logic [31:0] dataMem [0:255];
    int          progWords;
    int          storeCount;
    int          storeBase;
    int          storesSeen;

    core u_core (
        .clk(clk), .rst(rst), .instr(instr), .pc(pc), .memReadData(memReadData),
        .memAddr(memAddr), .memWriteData(memWriteData), .memWriteEnable(memWriteEnable),
        .memReadEnable(memReadEnable), .memWriteMask(memWriteMask)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic string testName(input logic [31:0] id);
        case (id)
            32'd1:   return "aluOps";
            32'd2:   return "branches";
            32'd3:   return "loadUse";
            32'd4:   return "storeMasks";
            default: return "unknown";
        endcase
    endfunction

    function automatic logic [31:0] mergeBytes(input logic [31:0] old,
                                               input logic [31:0] data,
                                               input logic [3:0] mask);
        logic [31:0] merged;
        merged = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                merged[8*b +: 8] = data[8*b +: 8];
            end
        end
        return merged;
    endfunction

    task automatic reportFailure();
        $display("Verification failed");
        $fatal(1);
    endtask

    ////////////////////
    // memory models
    ////////////////////

    // both memories answer one cycle after the request.
    always @(posedge clk) begin
        instr <= instrMem[pc[9:2]];
        if (memReadEnable) begin
            memReadData <= dataMem[memAddr[9:2]];
        end
        if (memWriteEnable) begin
            dataMem[memAddr[9:2]] <= mergeBytes(dataMem[memAddr[9:2]], memWriteData,
                                                memWriteMask);
        end
    end

    ////////////////////
    // checks
    ////////////////////

    task automatic checkResetState();
        assert (pc == `CORE_RESET_PC && !memWriteEnable && !memReadEnable) else begin
            $display("Mismatch in resetState: expected pc %h enables 00, got pc %h enables %b%b",
                     `CORE_RESET_PC, pc, memWriteEnable, memReadEnable);
            reportFailure();
        end
    endtask

    task automatic checkStore();
        int          rec;
        logic [31:0] id;
        logic [31:0] expAddr;
        logic [31:0] expMask;
        logic [31:0] expData;
        assert (storesSeen < storeCount) else begin
            $display("Unexpected store to address %h after all expected stores", memAddr);
            reportFailure();
        end
        rec = storeBase + 4 * storesSeen;
        id = vectors[rec];
        expAddr = vectors[rec + 1];
        expMask = vectors[rec + 2];
        expData = vectors[rec + 3];
        assert (memAddr == expAddr && {28'd0, memWriteMask} == expMask
                && memWriteData == expData) else begin
            $display(
                "Mismatch in %s: expected addr %h mask %h data %h, got addr %h mask %h data %h",
                testName(id), expAddr, expMask[3:0], expData, memAddr, memWriteMask,
                memWriteData);
            reportFailure();
        end
        storesSeen++;
    endtask

    // outputs are settled by the falling edge.
    always @(negedge clk) begin
        if (!rst && memWriteEnable) begin
            checkStore();
        end
    end

    // ten cycles per program word plus reset and some slack.
    initial begin
        wait (progWords > 0);
        #((progWords * 10 + 20) * 10);
        $display("Timeout: only %0d of %0d expected stores appeared", storesSeen, storeCount);
        reportFailure();
    end

    initial begin
        rst = 1'b1;
        instr = '0;
        memReadData = '0;
        storesSeen = 0;
        $readmemh("tb/coreVectors.txt", vectors);
        for (int i = 0; i < 256; i++) begin
            instrMem[i] = 32'h0000_0013 | (32'(i) << 20);
            dataMem[i] = (32'(i) * 32'h0101_0101) ^ 32'h5a00_00a5;
        end
        storeCount = int'(vectors[1 + int'(vectors[0])]);
        storeBase = 2 + int'(vectors[0]);
        for (int i = 0; i < int'(vectors[0]); i++) begin
            instrMem[i] = vectors[1 + i];
        end
        progWords = int'(vectors[0]);

        repeat (9) begin
            @(negedge clk);
            checkResetState();
        end
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkResetState();

        wait (storesSeen == storeCount);
        // a few more cycles to catch a stray store.
        repeat (5) @(posedge clk);
        $display("Verification passed");
        $finish;
    end

endmodule

//--- core.f
+incdir+src
src/corePkg.sv
src/programCounter.sv
src/instrDecoder.sv
src/regFile.sv
src/intAlu.sv
src/lsu.sv
src/core.sv
tb/coreTb.sv

//--- Makefile
TOP := coreTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f core.f --top-module $(TOP) -o V$(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Verification passed"

lint:
	verilator --lint-only -Wall --timing -f core.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- tb/coreVectors.txt
// program: word count, then instruction words in address order from 0.
// stores: record count, then test id (1 aluOps, 2 branches, 3 loadUse, 4 storeMasks),
// address, byte mask and data of each expected store, in program order.
56
// base x10, add, sub, first stores
10000513 00500093 ffd08113 002081b3 40310233 00352023 00452223
// shifts, xor, compares, and, stores
00421293 4022d313 01c2d393 00734433 001224b3 001235b3 00347633
00852423 00952623 00b52823 00c52a23
// lui, auipc, ori, stores
123456b7 00001717 6786e793 00e52c23 00f52e23
// per condition: not taken, marker, taken, two skipped stores, marker
00208463 02152023 00108663 0e052e23 0e052e23 02152223
00109463 02152423 00209663 0e052e23 0e052e23 02152623
0040c463 02152823 00124663 0e052e23 0e052e23 02152a23
00125463 02152c23 0040d663 0e052e23 0e052e23 02152e23
00126463 04152023 0040e663 0e052e23 0e052e23 04152223
0040f463 04152423 00127663 0e052e23 0e052e23 04152623
// jal and jalr with link stores
00c0086f 0e052e23 0e052e23 05052823
11000893 00188967 0e052e23 0e052e23 0e052e23 05252a23
// store, load, dependent add
04f52c23 05852a03 001a0ab3 05552e23
// byte and halfword stores, each word read back
06052023 06f50023 06c500a3 06350123 061501a3 06052b83 07752423
06052223 06f51223 06e51323 06452c03 07852623
// spin
0000006f
22
1 00000100 f 00000007
1 00000104 f fffffffb
1 00000108 f ffffffe3
1 0000010c f 00000001
1 00000110 f 00000000
1 00000114 f 00000003
1 00000118 f 0000104c
1 0000011c f 12345678
2 00000120 f 00000005
2 00000124 f 00000005
2 00000128 f 00000005
2 0000012c f 00000005
2 00000130 f 00000005
2 00000134 f 00000005
2 00000138 f 00000005
2 0000013c f 00000005
2 00000140 f 00000005
2 00000144 f 00000005
2 00000148 f 00000005
2 0000014c f 00000005
2 00000150 f 000000f0
2 00000154 f 00000104
3 00000158 f 12345678
3 0000015c f 1234567d
4 00000160 f 00000000
4 00000160 1 78787878
4 00000161 2 03030303
4 00000162 4 07070707
4 00000163 8 05050505
4 00000168 f 05070378
4 00000164 f 00000000
4 00000164 3 56785678
4 00000166 c 104c104c
4 0000016c f 104c5678
